// ==== design/mc_defs.svh ====
`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// ====================
// Datapath widths
// ====================

// Word address into the application port
`define MC_ADDR_W 28
// One memory word, also the width of store data and atomic operands
`define MC_DATA_W 32
// A load covers the strip count plus one consecutive words
`define MC_STRIP_W 2

// Request FIFO entries
`define MC_FIFO_DEPTH 4
// Cycles outside IDLE before a command is given up
`define MC_TIMEOUT 64

`endif

// ==== design/mc_pkg.sv ====
`default_nettype none

`include "mc_defs.svh"

package mc_pkg;

	// Command opcodes
	// MIN and MAX compare as signed, MINU and MAXU as unsigned
	typedef enum logic [3:0] {
		LOAD  = 4'd0,
		STORE = 4'd1,
		ADD   = 4'd2,
		AND   = 4'd3,
		OR    = 4'd4,
		EOR   = 4'd5,
		MIN   = 4'd6,
		MAX   = 4'd7,
		MINU  = 4'd8,
		MAXU  = 4'd9
	} mc_cmd_t;

	// Sequencer states
	// Encoded in four bits so that a corrupted register can be spotted
	typedef enum logic [3:0] {
		IDLE       = 4'd0,
		PRESET     = 4'd1,
		WRITE_CMD  = 4'd2,
		WRITE_DATA = 4'd3,
		READ_CMD   = 4'd4,
		READ_WAIT  = 4'd5,
		ALU        = 4'd6,
		DONE       = 4'd7
	} mc_state_t;

	// One queued command
	// The data field is the store word or the atomic operand
	typedef struct packed {
		mc_cmd_t                cmd;
		logic [`MC_ADDR_W-1:0]  addr;
		logic [`MC_DATA_W-1:0]  data;
		logic [`MC_STRIP_W-1:0] strips;
	} mc_req_t;

endpackage

`default_nettype wire

// ==== design/mc_seq_if.sv ====
`default_nettype none

`include "mc_defs.svh"

// Status that the sequencer and the strip tracker exchange
// The application port only looks at it
interface mc_seq_if import mc_pkg::*; ();
	mc_state_t state;
	// Number of read commands already accepted for the current load
	logic [`MC_STRIP_W-1:0] req_cnt;
	// The strip being issued or returned is the final one
	logic req_last;
	logic resp_last;
	// Watchdog fired
	logic to;

	modport seq (output state, input req_last, input resp_last, input to);
	modport tracker (input state, output req_cnt, output req_last, output resp_last, output to);
	modport port (input state, input req_cnt, input to);
endinterface

`default_nettype wire

// ==== design/mc_req_fifo.sv ====
`default_nettype none

`include "mc_defs.svh"

module mc_req_fifo import mc_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    wr,
	input  mc_req_t din,
	input  logic    pop,
	output mc_req_t head,
	output logic    empty,
	output logic    full
);

	localparam int DEPTH = `MC_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	mc_req_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	// A write while full is lost, a pop while empty does nothing
	assign do_wr = wr && !full;
	assign do_rd = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	// The oldest entry sits at the read pointer
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Pointers wrap explicitly so the depth need not be a power of two
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
		end
	end

	// The requester must watch full before it strobes
	a_no_write_full: assert property (@(posedge clk) disable iff (rst) wr |-> !full);
	// The sequencer only retires a command that is really there
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

// ==== design/mc_sequencer.sv ====
`default_nettype none

module mc_sequencer import mc_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    calib_complete,
	input  logic    empty,
	input  mc_req_t head,
	input  logic    app_rdy,
	input  logic    app_wdf_rdy,
	input  logic    app_rd_data_valid,
	mc_seq_if.seq   seq,
	output logic    pop
);

	mc_state_t next_state;
	// Remembers a timeout so the abandoned command is popped a cycle later
	logic to_q;
	logic atomic;

	assign atomic = !(head.cmd inside {LOAD, STORE});

	// Retire the command when it is finished or when it was abandoned
	assign pop = (seq.state == DONE) || to_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			seq.state <= IDLE;
			to_q <= 1'b0;
		end else begin
			seq.state <= next_state;
			to_q <= seq.to;
		end
	end

	// ====================
	// Next state
	// ====================
	always_comb begin
		next_state = seq.state;
		case (seq.state)
		// Hold off while a timed out entry is still being popped
		// because empty does not reflect that pop yet
		IDLE:
			if (!empty && calib_complete && !to_q) begin
				next_state = PRESET;
			end
		PRESET:
			if (head.cmd == STORE) begin
				next_state = WRITE_CMD;
			end else begin
				next_state = READ_CMD;
			end
		// The command is accepted when app_rdy is seen with app_en
		WRITE_CMD:
			if (app_rdy) begin
				next_state = WRITE_DATA;
			end
		WRITE_DATA:
			if (app_wdf_rdy) begin
				next_state = DONE;
			end
		// One read command goes out per strip, stay until the last is taken
		READ_CMD:
			if (app_rdy && seq.req_last) begin
				next_state = READ_WAIT;
			end
		// Loads finish on the last word, atomics go on to combine and write
		READ_WAIT:
			if (app_rd_data_valid && seq.resp_last) begin
				if (head.cmd == LOAD) begin
					next_state = DONE;
				end else begin
					next_state = ALU;
				end
			end
		ALU:
			next_state = WRITE_CMD;
		DONE:
			next_state = IDLE;
		default:
			next_state = IDLE;
		endcase
		// A hung command is dropped whatever the state
		if (seq.to) begin
			next_state = IDLE;
		end
	end

	a_state_legal: assert property (@(posedge clk) disable iff (rst)
		seq.state inside {IDLE, PRESET, WRITE_CMD, WRITE_DATA, READ_CMD, READ_WAIT, ALU, DONE});

	// A pop comes from DONE or from the IDLE cycle that follows a watchdog abort
	a_pop_cause: assert property (@(posedge clk) disable iff (rst)
		pop |-> (seq.state == DONE) || (seq.state == IDLE && $past(seq.to)));

	// The atomic path reads and writes exactly one word
	a_atomic_one_strip: assert property (@(posedge clk) disable iff (rst)
		(seq.state == PRESET && atomic) |-> (head.strips == '0));

endmodule

`default_nettype wire

// ==== design/mc_strip_tracker.sv ====
`default_nettype none

`include "mc_defs.svh"

module mc_strip_tracker import mc_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   calib_complete,
	input  logic [`MC_STRIP_W-1:0] strips,
	input  logic                   app_rdy,
	input  logic                   app_rd_data_valid,
	mc_seq_if.tracker              trk
);

	localparam int WD_W = $clog2(`MC_TIMEOUT + 1);

	logic [`MC_STRIP_W-1:0] resp_cnt;
	logic [WD_W-1:0] wd_cnt;
	logic reading;

	// Returns may already arrive while later strips are still being issued
	assign reading = (trk.state == READ_CMD) || (trk.state == READ_WAIT);

	// ====================
	// Strip counts
	// ====================
	always_ff @(posedge clk) begin
		if (rst || trk.state == PRESET) begin
			trk.req_cnt <= '0;
			resp_cnt <= '0;
		end else begin
			if (trk.state == READ_CMD && app_rdy) begin
				trk.req_cnt <= trk.req_cnt + 1'b1;
			end
			if (reading && app_rd_data_valid) begin
				resp_cnt <= resp_cnt + 1'b1;
			end
		end
	end

	assign trk.req_last = (trk.req_cnt == strips);
	assign trk.resp_last = (resp_cnt == strips);

	// Watchdog counts every cycle a command is in flight and saturates
	always_ff @(posedge clk) begin
		if (rst || trk.state == IDLE) begin
			wd_cnt <= '0;
		end else if (wd_cnt != WD_W'(`MC_TIMEOUT)) begin
			wd_cnt <= wd_cnt + 1'b1;
		end
	end

	// No timeout during calibration
	// IDLE and DONE are excluded so a finished command is never flagged
	assign trk.to = calib_complete && (wd_cnt == WD_W'(`MC_TIMEOUT)) &&
		!(trk.state inside {IDLE, DONE});

endmodule

`default_nettype wire

// ==== design/mc_app_port.sv ====
`default_nettype none

`include "mc_defs.svh"

module mc_app_port import mc_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  mc_req_t               head,
	mc_seq_if.port                port,
	input  logic                  app_rdy,
	output logic                  app_en,
	output logic [2:0]            app_cmd,
	output logic [`MC_ADDR_W-1:0] app_addr,
	output logic                  app_wdf_wren,
	output logic                  app_wdf_end,
	output logic [`MC_DATA_W-1:0] app_wdf_data,
	input  logic                  app_wdf_rdy,
	input  logic [`MC_DATA_W-1:0] app_rd_data,
	input  logic                  app_rd_data_valid,
	output logic                  resp_valid,
	output logic [`MC_DATA_W-1:0] resp_data,
	output logic                  resp_err
);

	localparam logic [2:0] APP_CMD_WR = 3'd0;
	localparam logic [2:0] APP_CMD_RD = 3'd1;

	logic [`MC_DATA_W-1:0] alu_res;
	logic [`MC_DATA_W-1:0] alu_q;
	logic rd_cmd;

	// ====================
	// Command and data strobes
	// ====================
	assign rd_cmd = (port.state == READ_CMD);
	assign app_en = rd_cmd || (port.state == WRITE_CMD);
	assign app_cmd = rd_cmd ? APP_CMD_RD : APP_CMD_WR;
	// Loads step through consecutive words, writes always go to the base address
	assign app_addr = rd_cmd ? head.addr + `MC_ADDR_W'(port.req_cnt) : head.addr;
	assign app_wdf_wren = (port.state == WRITE_DATA);
	// Every write is a single beat
	assign app_wdf_end = app_wdf_wren;
	assign app_wdf_data = (head.cmd == STORE) ? head.data : alu_q;

	// The returned word is both the response and the old value for an atomic
	always_ff @(posedge clk) begin
		if (app_rd_data_valid) begin
			resp_data <= app_rd_data;
		end
	end

	// Combine the old word with the operand
	always_comb begin
		case (head.cmd)
		ADD:     alu_res = resp_data + head.data;
		AND:     alu_res = resp_data & head.data;
		OR:      alu_res = resp_data | head.data;
		EOR:     alu_res = resp_data ^ head.data;
		MIN:     alu_res = ($signed(resp_data) < $signed(head.data)) ? resp_data : head.data;
		MAX:     alu_res = ($signed(resp_data) > $signed(head.data)) ? resp_data : head.data;
		MINU:    alu_res = (resp_data < head.data) ? resp_data : head.data;
		MAXU:    alu_res = (resp_data > head.data) ? resp_data : head.data;
		default: alu_res = head.data;
		endcase
	end

	// One register stage, loaded during the ALU state
	always_ff @(posedge clk) begin
		if (port.state == ALU) begin
			alu_q <= alu_res;
		end
	end

	// Stray returns outside a read phase are not reported
	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid <= 1'b0;
			resp_err <= 1'b0;
		end else begin
			resp_valid <= app_rd_data_valid &&
				(rd_cmd || port.state == READ_WAIT);
			resp_err <= port.to;
		end
	end

	a_wdf_hold: assert property (@(posedge clk) disable iff (rst)
		(app_wdf_wren && !app_wdf_rdy) |=> $stable(app_wdf_data));

	// A refused command stays on the pins unchanged until it is taken
	a_cmd_hold: assert property (@(posedge clk) disable iff (rst || port.to)
		(app_en && !app_rdy) |=> app_en && $stable(app_addr) && $stable(app_cmd));

endmodule

`default_nettype wire

// ==== design/memctl_top.sv ====
`default_nettype none

`include "mc_defs.svh"

module memctl_top import mc_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   calib_complete,
	// Request side
	input  logic                   req_wr,
	input  mc_cmd_t                req_cmd,
	input  logic [`MC_ADDR_W-1:0]  req_addr,
	input  logic [`MC_DATA_W-1:0]  req_data,
	input  logic [`MC_STRIP_W-1:0] req_strips,
	output logic                   req_full,
	// Application port
	input  logic                   app_rdy,
	output logic                   app_en,
	output logic [2:0]             app_cmd,
	output logic [`MC_ADDR_W-1:0]  app_addr,
	output logic                   app_wdf_wren,
	output logic                   app_wdf_end,
	output logic [`MC_DATA_W-1:0]  app_wdf_data,
	input  logic                   app_wdf_rdy,
	input  logic [`MC_DATA_W-1:0]  app_rd_data,
	input  logic                   app_rd_data_valid,
	// Responses
	output logic                   resp_valid,
	output logic [`MC_DATA_W-1:0]  resp_data,
	output logic                   resp_err
);

	mc_req_t req_din;
	mc_req_t head;
	logic empty;
	logic pop;

	mc_seq_if seq_bus ();

	assign req_din = '{cmd: req_cmd, addr: req_addr, data: req_data, strips: req_strips};

	mc_req_fifo i_req_fifo (
		.clk   (clk),
		.rst   (rst),
		.wr    (req_wr),
		.din   (req_din),
		.pop   (pop),
		.head  (head),
		.empty (empty),
		.full  (req_full)
	);

	mc_sequencer i_sequencer (
		.clk               (clk),
		.rst               (rst),
		.calib_complete    (calib_complete),
		.empty             (empty),
		.head              (head),
		.app_rdy           (app_rdy),
		.app_wdf_rdy       (app_wdf_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.seq               (seq_bus.seq),
		.pop               (pop)
	);

	mc_strip_tracker i_strip_tracker (
		.clk               (clk),
		.rst               (rst),
		.calib_complete    (calib_complete),
		.strips            (head.strips),
		.app_rdy           (app_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.trk               (seq_bus.tracker)
	);

	mc_app_port i_app_port (
		.clk               (clk),
		.rst               (rst),
		.head              (head),
		.port              (seq_bus.port),
		.app_rdy           (app_rdy),
		.app_en            (app_en),
		.app_cmd           (app_cmd),
		.app_addr          (app_addr),
		.app_wdf_wren      (app_wdf_wren),
		.app_wdf_end       (app_wdf_end),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_rdy       (app_wdf_rdy),
		.app_rd_data       (app_rd_data),
		.app_rd_data_valid (app_rd_data_valid),
		.resp_valid        (resp_valid),
		.resp_data         (resp_data),
		.resp_err          (resp_err)
	);

endmodule

`default_nettype wire

// ==== testbench/memctl_tb.sv ====
`default_nettype none

`include "mc_defs.svh"

module memctl_tb import mc_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEED = 32'h26d71748;
	// Commands issued over all tests times the worst case for one, plus margin
	localparam int N_CMDS = 42;
	localparam int CMD_WORST = 80;
	localparam int TIMEOUT_CYCLES = N_CMDS * CMD_WORST + 640;
	localparam int CALIB_HOLD = 12;
	// App command codes as the memory side sees them
	localparam logic [2:0] CMD_WR = 3'd0;
	localparam logic [2:0] CMD_RD = 3'd1;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic calib_complete = 1'b1;
	logic req_wr = 1'b0;
	mc_cmd_t req_cmd = LOAD;
	logic [`MC_ADDR_W-1:0] req_addr = '0;
	logic [`MC_DATA_W-1:0] req_data = '0;
	logic [`MC_STRIP_W-1:0] req_strips = '0;
	logic req_full;
	logic app_rdy = 1'b0;
	logic app_en;
	logic [2:0] app_cmd;
	logic [`MC_ADDR_W-1:0] app_addr;
	logic app_wdf_wren;
	logic app_wdf_end;
	logic [`MC_DATA_W-1:0] app_wdf_data;
	logic app_wdf_rdy = 1'b0;
	logic [`MC_DATA_W-1:0] app_rd_data = '0;
	logic app_rd_data_valid = 1'b0;
	logic resp_valid;
	logic [`MC_DATA_W-1:0] resp_data;
	logic resp_err;

	// Memory model and the shadow copy that expected values come from
	logic [`MC_DATA_W-1:0] mem [256];
	logic [`MC_DATA_W-1:0] shadow [256];
	logic [`MC_DATA_W-1:0] rd_data_q [$];
	int rd_due_q [$];
	// Expected traffic in program order
	logic [`MC_ADDR_W-1:0] exp_rd_addr [$];
	logic [`MC_ADDR_W-1:0] exp_wr_addr [$];
	logic [`MC_DATA_W-1:0] exp_wr_data [$];
	logic [`MC_DATA_W-1:0] exp_resp [$];
	logic [`MC_ADDR_W-1:0] wr_addr = '0;
	int model_seed = SEED;
	int stim_seed = SEED + 1;
	int cycles = 0;
	int last_due = 0;
	int rd_delay;
	int drop_reads = 0;
	int err_pending = 0;
	int full_hits = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	bit stall_en = 1'b0;

	memctl_top i_memctl_top (.*);

	always #20 clk = ~clk;

	task automatic count_error(input string msg);
		$display("Error %0t: %s", $time, msg);
		errors = errors + 1;
	endtask

	// Every word differs in each byte lane, so a wrong index shows up
	function automatic logic [`MC_DATA_W-1:0] fill_word(input int idx);
		return {8'(idx), ~8'(idx), 8'(idx) ^ 8'h5a, 8'(idx) + 8'h33};
	endfunction

	function automatic logic [`MC_DATA_W-1:0] atomic_result(input mc_cmd_t op,
			input logic [`MC_DATA_W-1:0] old, input logic [`MC_DATA_W-1:0] opnd);
		logic signed [`MC_DATA_W-1:0] s_old;
		logic signed [`MC_DATA_W-1:0] s_opnd;
		s_old = old;
		s_opnd = opnd;
		case (op)
		ADD:     return old + opnd;
		AND:     return old & opnd;
		OR:      return old | opnd;
		EOR:     return old ^ opnd;
		MIN:     return (s_old <= s_opnd) ? old : opnd;
		MAX:     return (s_old >= s_opnd) ? old : opnd;
		MINU:    return (old <= opnd) ? old : opnd;
		MAXU:    return (old >= opnd) ? old : opnd;
		default: return opnd;
		endcase
	endfunction

	// ====================
	// Memory model
	// ====================
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (!rst && app_en && app_rdy) begin
			if (app_cmd == CMD_RD) begin
				assert (exp_rd_addr.size() > 0 && app_addr == exp_rd_addr[0])
				else count_error($sformatf("read command to %h was not expected", app_addr));
				if (exp_rd_addr.size() > 0)
					void'(exp_rd_addr.pop_front());
				// A withheld read is accepted and never answered
				if (drop_reads > 0) begin
					drop_reads = drop_reads - 1;
				end else begin
					rd_delay = 1 + ($random(model_seed) & 3);
					last_due = (cycles + rd_delay > last_due) ? cycles + rd_delay : last_due + 1;
					rd_due_q.push_back(last_due);
					rd_data_q.push_back(mem[app_addr[7:0]]);
				end
			end else if (app_cmd == CMD_WR) begin
				assert (exp_wr_addr.size() > 0 && app_addr == exp_wr_addr[0])
				else count_error($sformatf("write command to %h was not expected", app_addr));
				if (exp_wr_addr.size() > 0)
					void'(exp_wr_addr.pop_front());
				wr_addr = app_addr;
			end else begin
				count_error($sformatf("unknown app command code %0d", app_cmd));
			end
		end
		if (!rst && app_wdf_wren && app_wdf_rdy) begin
			assert (exp_wr_data.size() > 0 && app_wdf_data == exp_wr_data[0])
			else count_error($sformatf("write data %h was not expected", app_wdf_data));
			if (exp_wr_data.size() > 0)
				void'(exp_wr_data.pop_front());
			mem[wr_addr[7:0]] = app_wdf_data;
		end
		if (!rst && resp_valid) begin
			assert (err_pending == 0)
			else count_error("a response came back for a command that should be abandoned");
			assert (exp_resp.size() > 0 && resp_data == exp_resp[0])
			else count_error($sformatf("response data %h was not expected", resp_data));
			if (exp_resp.size() > 0)
				void'(exp_resp.pop_front());
		end
		if (!rst && resp_err) begin
			assert (err_pending > 0) else count_error("an error pulse came with no command hung");
			if (err_pending > 0)
				err_pending = err_pending - 1;
		end
		// Returns leave in order once their delay has run out
		if (rd_due_q.size() > 0 && rd_due_q[0] <= cycles) begin
			void'(rd_due_q.pop_front());
			app_rd_data <= rd_data_q.pop_front();
			app_rd_data_valid <= 1'b1;
		end else begin
			app_rd_data_valid <= 1'b0;
		end
		app_rdy <= stall_en ? (($random(model_seed) & 3) != 0) : 1'b1;
		app_wdf_rdy <= stall_en ? (($random(model_seed) & 3) != 0) : 1'b1;
	end

	// ====================
	// Protocol checks
	// ====================
	a_reset_idle: assert property (@(posedge clk) $fell(rst) |->
		!app_en && !app_wdf_wren && !resp_valid && !resp_err && !req_full)
		else count_error("outputs are not idle after reset");
	a_no_cmd_uncal: assert property (@(posedge clk) disable iff (rst)
		!calib_complete |-> !app_en)
		else count_error("app_en raised while calibration is pending");
	a_addr_hold: assert property (@(posedge clk) disable iff (rst)
		(app_en && !app_rdy) |=> app_en && $stable(app_addr) && $stable(app_cmd))
		else count_error("stalled command changed");
	a_wdata_hold: assert property (@(posedge clk) disable iff (rst)
		(app_wdf_wren && !app_wdf_rdy) |=> app_wdf_wren && $stable(app_wdf_data))
		else count_error("stalled write beat changed");
	a_wdf_end: assert property (@(posedge clk) disable iff (rst) app_wdf_end == app_wdf_wren)
		else count_error("app_wdf_end differs from app_wdf_wren");
	a_err_once: assert property (@(posedge clk) disable iff (rst) resp_err |=> !resp_err)
		else count_error("resp_err is longer than one cycle");

	// Books the expected traffic, then queues the request when the FIFO has room
	task automatic send_cmd(input mc_cmd_t cmd, input logic [`MC_ADDR_W-1:0] addr,
			input logic [`MC_DATA_W-1:0] data, input int strips, input bit abandon);
		logic [`MC_ADDR_W-1:0] a;
		logic [`MC_DATA_W-1:0] res;
		if (cmd == STORE) begin
			exp_wr_addr.push_back(addr);
			exp_wr_data.push_back(data);
			shadow[addr[7:0]] = data;
		end else begin
			for (int i = 0; i <= strips; i++) begin
				a = addr + `MC_ADDR_W'(i);
				exp_rd_addr.push_back(a);
				if (!abandon)
					exp_resp.push_back(shadow[a[7:0]]);
			end
			if (abandon) begin
				drop_reads = drop_reads + strips + 1;
				err_pending = err_pending + 1;
			end
			if (cmd != LOAD) begin
				res = atomic_result(cmd, shadow[addr[7:0]], data);
				exp_wr_addr.push_back(addr);
				exp_wr_data.push_back(res);
				shadow[addr[7:0]] = res;
			end
		end
		@(negedge clk);
		while (req_full) begin
			full_hits = full_hits + 1;
			@(negedge clk);
		end
		@(posedge clk);
		req_wr <= 1'b1;
		req_cmd <= cmd;
		req_addr <= addr;
		req_data <= data;
		req_strips <= `MC_STRIP_W'(strips);
		@(posedge clk);
		req_wr <= 1'b0;
	endtask

	task automatic wait_drain();
		@(negedge clk);
		while (exp_rd_addr.size() + exp_wr_addr.size() + exp_wr_data.size() +
				exp_resp.size() + err_pending != 0)
			@(negedge clk);
	endtask

	task automatic close_test(input string name, input int mark);
		tests_run = tests_run + 1;
		if (errors == mark) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("Test %0d %s: FAILED with %0d errors", tests_run, name, errors - mark);
		end
	endtask

	initial begin
		while (cycles < TIMEOUT_CYCLES)
			@(negedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int mark;
		int k;
		mc_cmd_t op;
		logic [`MC_ADDR_W-1:0] a;
		logic [`MC_DATA_W-1:0] v;
		logic [`MC_DATA_W-1:0] w;
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i);
			shadow[i] = fill_word(i);
		end

		mark = errors;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		close_test("reset state", mark);

		// Four stores, then loads of one to four strips over them
		mark = errors;
		for (int i = 0; i < 4; i++) begin
			v = $random(stim_seed);
			send_cmd(STORE, 28'h40 + `MC_ADDR_W'(i), v, 0, 1'b0);
		end
		for (int i = 0; i < 4; i++)
			send_cmd(LOAD, 28'h40, '0, i, 1'b0);
		wait_drain();
		close_test("store then load", mark);

		// Negative old word and positive operand split signed from unsigned compares
		mark = errors;
		for (int i = 2; i <= 9; i++) begin
			op = mc_cmd_t'(4'(i));
			v = $random(stim_seed);
			w = $random(stim_seed);
			v[31] = 1'b1;
			w[31] = 1'b0;
			send_cmd(STORE, 28'h80 + `MC_ADDR_W'(i), v, 0, 1'b0);
			send_cmd(op, 28'h80 + `MC_ADDR_W'(i), w, 0, 1'b0);
		end
		wait_drain();
		close_test("atomic operations", mark);

		mark = errors;
		stall_en = 1'b1;
		full_hits = 0;
		for (int i = 0; i < 12; i++) begin
			k = $unsigned($random(stim_seed)) % 10;
			op = mc_cmd_t'(4'(k));
			a = `MC_ADDR_W'($random(stim_seed));
			v = $random(stim_seed);
			k = (op == LOAD) ? $unsigned($random(stim_seed)) % 4 : 0;
			send_cmd(op, a, v, k, 1'b0);
		end
		wait_drain();
		stall_en = 1'b0;
		assert (full_hits > 0) else count_error("the request FIFO never filled up");
		close_test("back-pressure", mark);

		// Requests pile up until the FIFO is full while calibration runs
		mark = errors;
		@(posedge clk);
		calib_complete <= 1'b0;
		for (int i = 0; i < 3; i++)
			send_cmd(STORE, 28'h20 + `MC_ADDR_W'(i), $random(stim_seed), 0, 1'b0);
		send_cmd(LOAD, 28'h20, '0, 2, 1'b0);
		@(negedge clk);
		assert (req_full) else count_error("req_full stayed low with four requests queued");
		repeat (CALIB_HOLD) @(posedge clk);
		calib_complete <= 1'b1;
		wait_drain();
		close_test("calibration hold", mark);

		mark = errors;
		send_cmd(LOAD, 28'h60, '0, 1, 1'b1);
		send_cmd(LOAD, 28'h40, '0, 2, 1'b0);
		wait_drain();
		close_test("abandoned load", mark);

		$display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== memctl.f ====
+incdir+design
design/mc_pkg.sv
design/mc_seq_if.sv
design/mc_req_fifo.sv
design/mc_sequencer.sv
design/mc_strip_tracker.sv
design/mc_app_port.sv
design/memctl_top.sv
testbench/memctl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module memctl_tb \
	-f memctl.f -o memctl_sim > build.log 2>&1 \
	&& ./obj_dir/memctl_sim > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
